/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_addr_t;

    // instruction layout: op | rs | rt | rd | funct, imm in the low byte
    localparam int opcode_msb = 15;
    localparam int rs_msb     = 11;
    localparam int rt_msb     = 9;
    localparam int rd_msb     = 7;
    localparam int imm_width  = 8;

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_bgz   = 4'd2,
        op_blz   = 4'd3,
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_jmp   = 4'd9,
        op_jal   = 4'd10,
        op_rtype = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,
        fn_shl = 6'd6,
        fn_shr = 6'd7,
        fn_jpr = 6'd25,
        fn_jrl = 6'd26,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } funct_e;

    // same order as funct 0..7
    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_not, alu_tcp, alu_shl, alu_shr
    } alu_op_e;

    localparam reg_addr_t link_reg = 2'd2;
    localparam word_t     nop_word = {op_rtype, 6'd0, fn_add};

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire logic  clk,
    input  wire logic  reset_n,
    input  wire word_t inst,
    input  wire logic  redirect,
    input  wire word_t redirect_pc,
    input  wire logic  stop,
    output word_t      inst_addr,
    output word_t      if_inst,
    output word_t      if_pc,
    output word_t      if_next_pc,
    output logic       if_valid
);

    word_t pc;
    logic  stopped;   // sticky once hlt is seen in decode
    logic  bubble;

    assign inst_addr = pc;
    assign bubble    = redirect | stop | stopped;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= reset_pc;
            stopped  <= 1'b0;
            if_valid <= 1'b0;
            if_inst  <= nop_word;
        end else begin
            stopped <= stopped | stop;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!(stop || stopped)) begin
                pc <= pc + 16'd1;   // always predict pc+1
            end
            if_valid <= ~bubble;
            if_inst  <= bubble ? nop_word : inst;
        end
    end

    // payload only, qualified by if_valid
    always_ff @(posedge clk) begin
        if_pc      <= pc;
        if_next_pc <= pc + 16'd1;
    end

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire reg_addr_t rs_addr,
    input  wire reg_addr_t rt_addr,
    input  wire reg_addr_t wb_dest,
    input  wire logic      wb_write,
    input  wire word_t     wb_data,
    output word_t          rs_data,
    output word_t          rt_data
);

    localparam int num_regs = 2 ** $bits(reg_addr_t);

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // write-through so a wb in the same cycle is seen by decode
    assign rs_data = (wb_write && wb_dest == rs_addr) ? wb_data : regs[rs_addr];
    assign rt_data = (wb_write && wb_dest == rt_addr) ? wb_data : regs[rt_addr];

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire word_t     if_inst,
    input  wire word_t     if_pc,
    input  wire word_t     if_next_pc,
    input  wire logic      if_valid,
    input  wire word_t     rs_data,
    input  wire word_t     rt_data,
    input  wire word_t     ex_result,
    input  wire reg_addr_t ex_dest,
    input  wire logic      ex_write,
    input  wire word_t     mem_result,
    input  wire reg_addr_t mem_dest,
    input  wire logic      mem_write,
    output reg_addr_t      rs_addr,
    output reg_addr_t      rt_addr,
    output logic           redirect,
    output word_t          redirect_pc,
    output logic           stop,
    output logic           id_valid,
    output alu_op_e        id_alu_op,
    output word_t          id_a,
    output word_t          id_b,
    output reg_addr_t      id_rs,
    output reg_addr_t      id_rt,
    output logic           id_use_imm,
    output word_t          id_imm,
    output reg_addr_t      id_dest,
    output logic           id_reg_write,
    output logic           id_link,
    output logic           id_wwd,
    output logic           id_halt,
    output word_t          id_next_pc
);

    opcode_e                opcode;
    funct_e                 funct;
    reg_addr_t              rd;
    logic [imm_width-1:0]   imm;
    word_t                  imm_sext, imm_zext;
    word_t                  fwd_a, fwd_b;
    word_t                  branch_target, jump_target;

    alu_op_e   alu_op;
    logic      use_imm, reg_write, link, wwd, halt, taken;
    word_t     imm_val, link_val, target;
    reg_addr_t dest;

    assign opcode   = opcode_e'(if_inst[opcode_msb -: 4]);
    assign funct    = funct_e'(if_inst[5:0]);
    assign rs_addr  = if_inst[rs_msb -: 2];
    assign rt_addr  = if_inst[rt_msb -: 2];
    assign rd       = if_inst[rd_msb -: 2];
    assign imm      = if_inst[imm_width-1:0];
    assign imm_sext = {{($bits(word_t) - imm_width){imm[imm_width-1]}}, imm};
    assign imm_zext = {{($bits(word_t) - imm_width){1'b0}}, imm};

    //////////////////// branch operands
    assign fwd_a = (ex_write && ex_dest == rs_addr)   ? ex_result  :
                   (mem_write && mem_dest == rs_addr) ? mem_result : rs_data;
    assign fwd_b = (ex_write && ex_dest == rt_addr)   ? ex_result  :
                   (mem_write && mem_dest == rt_addr) ? mem_result : rt_data;

    assign branch_target = if_next_pc + imm_sext;
    assign jump_target   = {if_pc[opcode_msb:rs_msb+1], if_inst[rs_msb:0]};

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        imm_val   = imm_sext;
        dest      = rd;
        reg_write = 1'b0;
        link      = 1'b0;
        link_val  = if_next_pc;
        wwd       = 1'b0;
        halt      = 1'b0;
        taken     = 1'b0;
        target    = branch_target;
        case (opcode)
            op_bne: taken = fwd_a != fwd_b;
            op_beq: taken = fwd_a == fwd_b;
            op_bgz: taken = $signed(fwd_a) > 16'sd0;
            op_blz: taken = $signed(fwd_a) < 16'sd0;
            op_adi: begin
                use_imm   = 1'b1;
                dest      = rt_addr;
                reg_write = 1'b1;
            end
            op_ori: begin
                alu_op    = alu_or;
                use_imm   = 1'b1;
                imm_val   = imm_zext;
                dest      = rt_addr;
                reg_write = 1'b1;
            end
            op_lhi: begin
                dest      = rt_addr;
                reg_write = 1'b1;
                link      = 1'b1;   // pass-through path carries the upper byte
                link_val  = {imm, {($bits(word_t) - imm_width){1'b0}}};
            end
            op_jmp: begin
                taken  = 1'b1;
                target = jump_target;
            end
            op_jal: begin
                taken     = 1'b1;
                target    = jump_target;
                dest      = link_reg;
                reg_write = 1'b1;
                link      = 1'b1;
            end
            op_rtype: begin
                case (funct)
                    fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
                        alu_op    = alu_op_e'(funct[2:0]);
                        reg_write = 1'b1;
                    end
                    fn_jpr: begin
                        taken  = 1'b1;
                        target = fwd_a;
                    end
                    fn_jrl: begin
                        taken     = 1'b1;
                        target    = fwd_a;
                        dest      = link_reg;
                        reg_write = 1'b1;
                        link      = 1'b1;
                    end
                    fn_wwd: wwd = 1'b1;
                    fn_hlt: halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;   // loads and stores fall through as no-ops
        endcase
    end

    assign redirect    = if_valid & taken;
    assign redirect_pc = target;
    assign stop        = if_valid & halt;

    //////////////////// id/ex
    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_valid     <= 1'b0;
            id_reg_write <= 1'b0;
            id_link      <= 1'b0;
            id_wwd       <= 1'b0;
            id_halt      <= 1'b0;
        end else begin
            id_valid     <= if_valid;
            id_reg_write <= reg_write;
            id_link      <= link;
            id_wwd       <= wwd;
            id_halt      <= halt;
        end
    end

    always_ff @(posedge clk) begin
        id_alu_op  <= alu_op;
        id_a       <= rs_data;
        id_b       <= rt_data;
        id_rs      <= rs_addr;
        id_rt      <= rt_addr;
        id_use_imm <= use_imm;
        id_imm     <= imm_val;
        id_dest    <= dest;
        id_next_pc <= link_val;
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire logic      id_valid,
    input  wire alu_op_e   id_alu_op,
    input  wire word_t     id_a,
    input  wire word_t     id_b,
    input  wire reg_addr_t id_rs,
    input  wire reg_addr_t id_rt,
    input  wire logic      id_use_imm,
    input  wire word_t     id_imm,
    input  wire reg_addr_t id_dest,
    input  wire logic      id_reg_write,
    input  wire logic      id_link,
    input  wire logic      id_wwd,
    input  wire logic      id_halt,
    input  wire word_t     id_next_pc,
    input  wire logic      wb_write,
    input  wire reg_addr_t wb_dest,
    input  wire word_t     wb_data,
    output word_t          ex_result,
    output reg_addr_t      ex_dest,
    output logic           ex_write,
    output logic           mem_valid,
    output word_t          mem_result,
    output reg_addr_t      mem_dest,
    output logic           mem_write,
    output logic           mem_wwd,
    output word_t          mem_wwd_value,
    output logic           mem_halt
);

    word_t op_a, fwd_b, op_b;
    word_t alu_out;

    //////////////////// operand forwarding, mem before wb
    assign op_a = (mem_write && mem_dest == id_rs) ? mem_result :
                  (wb_write && wb_dest == id_rs)   ? wb_data    : id_a;
    assign fwd_b = (mem_write && mem_dest == id_rt) ? mem_result :
                   (wb_write && wb_dest == id_rt)   ? wb_data    : id_b;
    assign op_b = id_use_imm ? id_imm : fwd_b;

    //////////////////// alu
    always_comb begin
        case (id_alu_op)
            alu_add: alu_out = op_a + op_b;
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_not: alu_out = ~op_a;
            alu_tcp: alu_out = ~op_a + 16'd1;
            alu_shl: alu_out = {op_a[14:0], 1'b0};
            alu_shr: alu_out = {op_a[15], op_a[15:1]};   // arithmetic
            default: alu_out = op_a + op_b;
        endcase
    end

    assign ex_result = id_link ? id_next_pc : alu_out;
    assign ex_dest   = id_dest;
    assign ex_write  = id_valid & id_reg_write;

    //////////////////// ex/mem
    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
            mem_wwd   <= 1'b0;
            mem_halt  <= 1'b0;
        end else begin
            mem_valid <= id_valid;
            mem_write <= ex_write;
            mem_wwd   <= id_wwd;
            mem_halt  <= id_halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_result    <= ex_result;
        mem_dest      <= ex_dest;
        mem_wwd_value <= op_a;   // wwd prints rs
    end

endmodule

`default_nettype wire

/* logic/writeback_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire logic      mem_valid,
    input  wire word_t     mem_result,
    input  wire reg_addr_t mem_dest,
    input  wire logic      mem_write,
    input  wire logic      mem_wwd,
    input  wire word_t     mem_wwd_value,
    input  wire logic      mem_halt,
    output logic           wb_write,
    output reg_addr_t      wb_dest,
    output word_t          wb_data,
    output word_t          output_port,
    output logic           output_valid,
    output logic           is_halted,
    output word_t          num_inst
);

    logic  wb_valid, wb_wwd, wb_halt;
    logic  halt_q;
    word_t wb_wwd_value;
    word_t port_q;

    //////////////////// mem/wb
    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_valid <= 1'b0;
            wb_write <= 1'b0;
            wb_wwd   <= 1'b0;
            wb_halt  <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
            wb_write <= mem_valid & mem_write;
            wb_wwd   <= mem_wwd;
            wb_halt  <= mem_halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest      <= mem_dest;
        wb_data      <= mem_result;
        wb_wwd_value <= mem_wwd_value;
    end

    //////////////////// status
    assign output_valid = wb_valid & wb_wwd;
    assign output_port  = output_valid ? wb_wwd_value : port_q;   // value shows in the wb slot
    assign is_halted    = halt_q | (wb_valid & wb_halt);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            port_q   <= '0;
            halt_q   <= 1'b0;
            num_inst <= '0;
        end else begin
            if (output_valid) begin
                port_q <= wb_wwd_value;
            end
            halt_q <= is_halted;   // sticky until reset
            if (wb_valid) begin
                num_inst <= num_inst + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu import cpu_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire logic  clk,
    input  wire logic  reset_n,
    input  wire word_t inst,
    output word_t      inst_addr,
    output word_t      output_port,
    output logic       output_valid,
    output logic       is_halted,
    output word_t      num_inst
);

    // if/id
    word_t     if_inst, if_pc, if_next_pc;
    logic      if_valid;
    logic      redirect, stop;
    word_t     redirect_pc;

    // register file
    reg_addr_t rs_addr, rt_addr;
    word_t     rs_data, rt_data;

    // id/ex
    logic      id_valid, id_use_imm, id_reg_write, id_link, id_wwd, id_halt;
    alu_op_e   id_alu_op;
    word_t     id_a, id_b, id_imm, id_next_pc;
    reg_addr_t id_rs, id_rt, id_dest;

    // ex and ex/mem
    word_t     ex_result, mem_result, mem_wwd_value;
    reg_addr_t ex_dest, mem_dest;
    logic      ex_write, mem_valid, mem_write, mem_wwd, mem_halt;

    // wb
    logic      wb_write;
    reg_addr_t wb_dest;
    word_t     wb_data;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk, .reset_n, .inst, .redirect, .redirect_pc, .stop,
        .inst_addr, .if_inst, .if_pc, .if_next_pc, .if_valid
    );

    register_file u_regs (
        .clk, .reset_n, .rs_addr, .rt_addr, .wb_dest, .wb_write, .wb_data,
        .rs_data, .rt_data
    );

    decode_stage u_decode (
        .clk, .reset_n, .if_inst, .if_pc, .if_next_pc, .if_valid,
        .rs_data, .rt_data,
        .ex_result, .ex_dest, .ex_write, .mem_result, .mem_dest, .mem_write,
        .rs_addr, .rt_addr, .redirect, .redirect_pc, .stop,
        .id_valid, .id_alu_op, .id_a, .id_b, .id_rs, .id_rt, .id_use_imm, .id_imm,
        .id_dest, .id_reg_write, .id_link, .id_wwd, .id_halt, .id_next_pc
    );

    execute_stage u_execute (
        .clk, .reset_n,
        .id_valid, .id_alu_op, .id_a, .id_b, .id_rs, .id_rt, .id_use_imm, .id_imm,
        .id_dest, .id_reg_write, .id_link, .id_wwd, .id_halt, .id_next_pc,
        .wb_write, .wb_dest, .wb_data,
        .ex_result, .ex_dest, .ex_write,
        .mem_valid, .mem_result, .mem_dest, .mem_write, .mem_wwd, .mem_wwd_value, .mem_halt
    );

    writeback_stage u_writeback (
        .clk, .reset_n,
        .mem_valid, .mem_result, .mem_dest, .mem_write, .mem_wwd, .mem_wwd_value, .mem_halt,
        .wb_write, .wb_dest, .wb_data,
        .output_port, .output_valid, .is_halted, .num_inst
    );

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 8
) (
    input  wire logic reset_req,
    output logic      clk,
    output logic      reset_n
);

    int count = reset_cycles;   // in reset from time zero

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

    always @(posedge clk) begin
        if (reset_req) begin
            count <= reset_cycles;
        end else if (count != 0) begin
            count <= count - 1;
        end
    end

    assign reset_n = (count != 0);   // high while in reset

endmodule

`default_nettype wire

/* dv/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam word_t     reset_pc    = 16'h0000;
    localparam int        num_rows    = 7;
    localparam int        prog_words  = 16;
    localparam int        max_outs    = 8;
    localparam int        hold_cycles = 5;
    localparam int        cycle_limit = num_rows * (prog_words + 8 + 16);
    localparam word_t     hlt_word    = {op_rtype, 6'd0, fn_hlt};
    localparam reg_addr_t r0          = 2'd0;
    localparam reg_addr_t r1          = 2'd1;
    localparam reg_addr_t r2          = 2'd2;
    localparam reg_addr_t r3          = 2'd3;

    logic  clk;
    logic  reset_n;
    logic  reset_req;
    word_t inst;
    word_t inst_addr;
    word_t output_port;
    word_t num_inst;
    logic  output_valid;
    logic  is_halted;

    word_t imem [prog_words];

    // test table
    string row_name      [num_rows];
    word_t row_prog      [num_rows][prog_words];
    word_t row_outs      [num_rows][max_outs];
    int    row_out_count [num_rows];
    word_t row_num_inst  [num_rows];
    int    row_idx;
    int    word_idx;

    word_t seen [$];   // every wwd value in arrival order
    int    cycles;
    int    mismatches;
    int    other_errors;

    clock_gen clocks (.reset_req, .clk, .reset_n);

    cpu #(.reset_pc(reset_pc)) dut (
        .clk, .reset_n, .inst,
        .inst_addr, .output_port, .output_valid, .is_halted, .num_inst
    );

    // async read with hlt outside the program
    assign inst = (inst_addr < 16'(prog_words)) ? imem[inst_addr[3:0]] : hlt_word;

    //////////////////// encoders
    function automatic word_t imm_inst(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                       logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t reg_inst(funct_e fn, reg_addr_t rs, reg_addr_t rt,
                                       reg_addr_t rd);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    task automatic begin_row(input string name, input word_t num_valid);
        row_idx++;
        word_idx = 0;
        row_name[row_idx]      = name;
        row_num_inst[row_idx]  = num_valid;
        row_out_count[row_idx] = 0;
        for (int i = 0; i < prog_words; i++) begin
            row_prog[row_idx][i] = hlt_word;
        end
    endtask

    task automatic add_word(input word_t w);
        row_prog[row_idx][word_idx] = w;
        word_idx++;
    endtask

    task automatic add_output(input word_t value);
        row_outs[row_idx][row_out_count[row_idx]] = value;
        row_out_count[row_idx]++;
    endtask

    task automatic build_table();
        begin_row("alu_arith", 16'd14);
        add_word(imm_inst(op_adi, r0, r1, 8'd5));
        add_word(imm_inst(op_lhi, r0, r2, 8'h12));
        add_word(imm_inst(op_adi, r0, r3, 8'hfd));    // sign extended
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(imm_inst(op_ori, r1, r3, 8'h81));    // zero extended
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(reg_inst(fn_add, r2, r1, r3));
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(reg_inst(fn_sub, r1, r2, r3));
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(reg_inst(fn_and, r3, r2, r3));
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(hlt_word);
        add_output(16'hfffd);
        add_output(16'h0085);
        add_output(16'h1200);
        add_output(16'h1205);
        add_output(16'hee05);
        add_output(16'h0200);

        begin_row("alu_unary", 16'd13);
        add_word(imm_inst(op_lhi, r0, r1, 8'h80));
        add_word(imm_inst(op_ori, r1, r1, 8'h06));
        add_word(reg_inst(fn_orr, r1, r0, r2));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(reg_inst(fn_not, r1, r0, r2));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(reg_inst(fn_tcp, r1, r0, r2));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(reg_inst(fn_shl, r1, r0, r2));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(reg_inst(fn_shr, r1, r0, r2));      // keeps the sign bit
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(hlt_word);
        add_output(16'h8006);
        add_output(16'h7ff9);
        add_output(16'h7ffa);
        add_output(16'h000c);
        add_output(16'hc003);

        begin_row("forwarding", 16'd14);
        add_word(imm_inst(op_adi, r0, r1, 8'd1));
        add_word(imm_inst(op_adi, r1, r1, 8'd2));     // distance 1
        add_word(imm_inst(op_adi, r0, r2, 8'd4));
        add_word(reg_inst(fn_add, r1, r2, r3));      // r1 at distance 2
        add_word(reg_inst(fn_add, r1, r3, r2));      // r1 at distance 3
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(imm_inst(op_adi, r0, r1, 8'd10));
        add_word(imm_inst(op_bne, r1, r2, 8'd1));     // operand from ex
        add_word(reg_inst(fn_wwd, r1, r0, r0));
        add_word(imm_inst(op_adi, r0, r3, 8'd10));
        add_word(reg_inst(fn_wwd, r0, r0, r0));
        add_word(imm_inst(op_beq, r3, r2, 8'd1));     // operand from mem
        add_word(reg_inst(fn_wwd, r3, r0, r0));      // squashed
        add_word(hlt_word);
        add_output(16'h0007);
        add_output(16'h000a);
        add_output(16'h000a);
        add_output(16'h0000);

        begin_row("branch_eq", 16'd10);
        add_word(imm_inst(op_adi, r0, r1, 8'd5));
        add_word(imm_inst(op_adi, r0, r2, 8'hfd));
        add_word(imm_inst(op_adi, r0, r3, 8'd5));
        add_word(imm_inst(op_beq, r1, r3, 8'd1));
        add_word(reg_inst(fn_wwd, r1, r0, r0));
        add_word(imm_inst(op_beq, r1, r2, 8'd1));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(imm_inst(op_bne, r1, r2, 8'd1));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(imm_inst(op_bne, r1, r3, 8'd1));
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(hlt_word);
        add_output(16'hfffd);
        add_output(16'h0005);

        begin_row("branch_sign", 16'd11);
        add_word(imm_inst(op_adi, r0, r1, 8'd5));
        add_word(imm_inst(op_adi, r0, r2, 8'hfd));
        add_word(imm_inst(op_bgz, r1, r0, 8'd1));
        add_word(reg_inst(fn_wwd, r1, r0, r0));
        add_word(imm_inst(op_bgz, r2, r0, 8'd1));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(imm_inst(op_bgz, r0, r0, 8'd1));     // zero is not above zero
        add_word(reg_inst(fn_wwd, r0, r0, r0));
        add_word(imm_inst(op_blz, r2, r0, 8'd1));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(imm_inst(op_blz, r1, r0, 8'd1));
        add_word(reg_inst(fn_wwd, r1, r0, r0));
        add_word(hlt_word);
        add_output(16'hfffd);
        add_output(16'h0000);
        add_output(16'h0005);

        begin_row("jumps", 16'd9);
        add_word(imm_inst(op_jal, r0, r0, 8'd2));
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(reg_inst(fn_wwd, r2, r0, r0));      // link from jal
        add_word(imm_inst(op_adi, r0, r1, 8'd6));
        add_word(reg_inst(fn_jpr, r1, r0, r0));
        add_word(reg_inst(fn_wwd, r1, r0, r0));
        add_word(imm_inst(op_adi, r0, r3, 8'd9));
        add_word(reg_inst(fn_jrl, r3, r0, r0));
        add_word(reg_inst(fn_wwd, r3, r0, r0));
        add_word(reg_inst(fn_wwd, r2, r0, r0));      // link from jrl
        add_word(imm_inst(op_jmp, r0, r0, 8'd12));
        add_word(reg_inst(fn_wwd, r2, r0, r0));
        add_word(hlt_word);
        add_output(16'h0001);
        add_output(16'h0008);

        begin_row("halt", 16'd4);
        add_word(imm_inst(op_adi, r0, r1, 8'h21));
        add_word(imm_inst(op_beq, r0, r0, 8'd1));
        add_word(reg_inst(fn_wwd, r0, r0, r0));
        add_word(reg_inst(fn_wwd, r1, r0, r0));
        add_word(hlt_word);
        add_word(reg_inst(fn_wwd, r1, r0, r0));      // past hlt
        add_word(reg_inst(fn_wwd, r0, r0, r0));
        add_output(16'h0021);
    endtask

    //////////////////// checking
    task automatic check_value(input string test, input string what,
                               input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic finish_run(input int timeouts);
        $display("errors: %0d mismatches, %0d other, %0d timeouts",
                 mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic run_row(input int r);
        int first;
        int got;
        @(posedge clk);
        reset_req <= 1'b1;
        for (int i = 0; i < prog_words; i++) begin
            imem[i] <= row_prog[r][i];
        end
        @(posedge clk);
        reset_req <= 1'b0;
        @(negedge clk);
        while (reset_n) begin
            @(negedge clk);
        end
        first = seen.size();
        check_value(row_name[r], "num_inst after reset", '0, num_inst);
        check_value(row_name[r], "is_halted after reset", '0, 16'(is_halted));
        check_value(row_name[r], "inst_addr after reset", reset_pc, inst_addr);
        check_value(row_name[r], "output_port after reset", '0, output_port);
        while (!is_halted) begin
            @(negedge clk);
        end
        repeat (hold_cycles) begin
            @(negedge clk);
            if (!is_halted) begin
                $display("test %s: is_halted went low after it had risen", row_name[r]);
                other_errors++;
            end
        end
        @(posedge clk);
        got = seen.size() - first;
        if (got != row_out_count[r]) begin
            $display("test %s: expected %0d WWD outputs but saw %0d",
                     row_name[r], row_out_count[r], got);
            other_errors++;
        end
        for (int k = 0; k < got && k < row_out_count[r]; k++) begin
            check_value(row_name[r], $sformatf("wwd output %0d", k),
                        row_outs[r][k], seen[first + k]);
        end
        check_value(row_name[r], "num_inst", row_num_inst[r], num_inst);
    endtask

    always @(negedge clk) begin
        if (output_valid) begin
            seen.push_back(output_port);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= cycle_limit);
        $display("timeout: tests still running after %0d cycles", cycles);
        finish_run(1);
    end

    initial begin
        reset_req <= 1'b0;
        for (int i = 0; i < prog_words; i++) begin
            imem[i] <= hlt_word;
        end
        row_idx = -1;
        build_table();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        finish_run(0);
    end

endmodule

`default_nettype wire

/* cpu.f */
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/cpu.sv
dv/clock_gen.sv
dv/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
